//--- list.f
source/glb_param_pkg.sv
source/glb_pkt_pkg.sv
source/glb_tile_cfg.sv
source/glb_tile_core.sv
source/glb_tile.sv
source/glb_rsp_egress.sv
source/glb_top.sv
testbench/glb_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the global buffer testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module glb_tb -o glb_sim &&
./obj_dir/glb_sim | tee sim.log &&
grep -qx "All checks passed" sim.log &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

//--- testbench/glb_tb.sv
// Directed testbench for the global buffer chain
// Host side keeps request credits and grants response credits as responses are due
// Bank contents are undefined after reset, so reads only target written words
`timescale 1ns/1ps
`default_nettype none

module glb_tb;
    import glb_param_pkg::*;
    import glb_pkt_pkg::*;

    logic     clk;
    logic     reset;
    req_pkt_t req_in;
    logic     req_credit;
    logic     rsp_credit;
    rsp_pkt_t rsp_out;

    // Reference model of every tile
    logic [DATA_WIDTH-1:0] ref_bank [NUM_TILES][BANK_WORDS];
    logic                  ref_written [NUM_TILES][BANK_WORDS];
    logic                  ref_on [NUM_TILES];
    logic [15:0]           ref_count [NUM_TILES];

    // Host bookkeeping
    rsp_pkt_t exp_q [$];
    rsp_pkt_t exp_rsp;
    int       errors;
    int       rsp_seen;
    int       req_credits;
    int       rsp_granted;
    int       host_limit;
    logic     grant_next;

    glb_top i_glb_top (
        .clk        (clk),
        .reset      (reset),
        .req_in     (req_in),
        .req_credit (req_credit),
        .rsp_credit (rsp_credit),
        .rsp_out    (rsp_out)
    );

    always #4 clk = ~clk;

    // Response credit pulse, decided at the previous falling edge
    always @(posedge clk) begin
        #1;
        rsp_credit = grant_next;
    end

    // Expected response for one request, model state updated in service order
    function automatic rsp_pkt_t model_service(input req_pkt_t r);
        rsp_pkt_t e;
        e           = '0;
        e.valid     = 1'b1;
        e.op        = r.op;
        e.status    = RSP_OK;
        e.tile_id   = r.tile_id;
        e.word_addr = r.word_addr;
        case (r.op)
            OP_WR, OP_RD: begin
                if (!ref_on[r.tile_id]) begin
                    e.status = RSP_OFF;
                end
                else begin
                    if (r.op == OP_WR) begin
                        ref_bank[r.tile_id][r.word_addr]    = r.data;
                        ref_written[r.tile_id][r.word_addr] = 1'b1;
                    end
                    e.data = ref_bank[r.tile_id][r.word_addr];
                    if (ref_count[r.tile_id] != 16'hffff) begin
                        ref_count[r.tile_id] = ref_count[r.tile_id] + 16'd1;
                    end
                end
            end
            OP_CFG_WR: begin
                ref_on[r.tile_id] = r.data[0];
                e.data            = r.data;
            end
            OP_CFG_RD: begin
                e.data[0]     = ref_on[r.tile_id];
                e.data[31:16] = ref_count[r.tile_id];
            end
            default: ;
        endcase
        return e;
    endfunction

    // Response checker and credit accounting, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            assert (req_credit == rsp_out.valid) else begin
                errors++;
                $display("ERR %0t req_credit got %b exp %b", $time, req_credit, rsp_out.valid);
            end
            if (rsp_out.valid) begin
                assert (rsp_granted != 0) else begin
                    errors++;
                    $display("%0t: response sent without a response credit", $time);
                end
                if (rsp_granted != 0) begin
                    rsp_granted--;
                end
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("%0t: response arrived with none expected", $time);
                end
                if (exp_q.size() != 0) begin
                    exp_rsp = exp_q.pop_front();
                    assert (rsp_out == exp_rsp) else begin
                        errors++;
                        $display("ERR %0t rsp_out got %h exp %h", $time, rsp_out, exp_rsp);
                    end
                end
                rsp_seen++;
            end
            if (req_credit) begin
                req_credits++;
            end
            // Grant only for responses still owed
            grant_next = 1'b0;
            if (rsp_granted < host_limit && rsp_granted < exp_q.size()) begin
                grant_next = 1'b1;
                rsp_granted++;
            end
        end
    end

    task automatic acquire_req_credit(output bit ok);
        int cycles;
        cycles = 0;
        while (req_credits == 0 && cycles < 100) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = (req_credits != 0);
        assert (ok) else begin
            errors++;
            $display("%0t: timeout waiting for a request credit", $time);
        end
    endtask

    // Drive one request for one cycle and queue its expected response
    task automatic send_req(input glb_op_e op, input int tile, input int addr,
                            input logic [DATA_WIDTH-1:0] data);
        req_pkt_t r;
        bit       ok;
        acquire_req_credit(ok);
        if (ok) begin
            r           = '0;
            r.valid     = 1'b1;
            r.op        = op;
            r.tile_id   = TILE_ID_WIDTH'(tile);
            r.word_addr = WORD_ADDR_WIDTH'(addr);
            r.data      = data;
            req_in      = r;
            req_credits--;
            exp_q.push_back(model_service(r));
            @(posedge clk);
            #1;
            req_in = '0;
        end
    endtask

    task automatic await_responses(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (rsp_seen < target && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (rsp_seen >= target) else begin
            errors++;
            $display("%0t: timeout waiting for response number %0d", $time, target);
        end
    endtask

    // All responses in, all request credits back
    task automatic drain_and_check(input int limit);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0t: timeout, %0d responses never arrived", $time, exp_q.size());
            exp_q.delete();
        end
        assert (req_credits == RSP_FIFO_DEPTH) else begin
            errors++;
            $display("ERR %0t req_credits got %0d exp %0d", $time, req_credits, RSP_FIFO_DEPTH);
        end
    endtask

    task automatic reset_idle();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (rsp_out.valid == 1'b0) else begin
                errors++;
                $display("ERR %0t rsp_out.valid got %b exp 0", $time, rsp_out.valid);
            end
            assert (req_credit == 1'b0) else begin
                errors++;
                $display("ERR %0t req_credit got %b exp 0", $time, req_credit);
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic write_then_read();
        send_req(OP_WR, 1, 3, 32'h1234_5678);
        drain_and_check(40);
        send_req(OP_RD, 1, 3, '0);
        drain_and_check(40);
    endtask

    // Same word in every tile, each tile keeps its own value
    task automatic bank_independence();
        for (int t = 0; t < NUM_TILES; t++) begin
            send_req(OP_WR, t, 9, 32'hC0DE_0000 + 32'(t * 17));
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            send_req(OP_RD, t, 9, '0);
        end
        drain_and_check(60);
    endtask

    task automatic config_access();
        send_req(OP_CFG_WR, 2, 0, 32'h0);
        send_req(OP_WR, 2, 9, 32'hDEAD_BEEF);
        send_req(OP_RD, 2, 9, '0);
        send_req(OP_CFG_WR, 2, 0, 32'h1);
        send_req(OP_RD, 2, 9, '0);
        send_req(OP_CFG_RD, 2, 0, '0);
        send_req(OP_CFG_RD, 1, 0, '0);
        drain_and_check(80);
    endtask

    // FIFO fills with no response credits, then drains one credit at a time
    task automatic backpressure_fill_drain();
        int base;
        host_limit = 0;
        base       = rsp_seen;
        for (int i = 0; i < RSP_FIFO_DEPTH; i++) begin
            send_req(OP_WR, i % NUM_TILES, 20 + i, $urandom);
        end
        repeat (30) @(posedge clk);
        assert (rsp_seen == base) else begin
            errors++;
            $display("%0t: response sent while the host gave no credit", $time);
        end
        assert (req_credits == 0) else begin
            errors++;
            $display("ERR %0t req_credits got %0d exp 0", $time, req_credits);
        end
        host_limit = 1;
        for (int i = 1; i <= RSP_FIFO_DEPTH; i++) begin
            await_responses(base + i, 40);
        end
        host_limit = RSP_FIFO_DEPTH;
        drain_and_check(40);
    endtask

    task automatic random_traffic(input int count);
        glb_op_e               op;
        int                    tile;
        int                    addr;
        logic [DATA_WIDTH-1:0] data;
        for (int i = 0; i < count; i++) begin
            tile = $urandom_range(NUM_TILES - 1);
            addr = $urandom_range(7);
            data = $urandom;
            case ($urandom_range(3))
                0:       op = OP_WR;
                1:       op = OP_RD;
                2:       op = OP_CFG_WR;
                default: op = OP_CFG_RD;
            endcase
            // Unwritten words hold no defined data
            if (op == OP_RD && !ref_written[tile][addr]) begin
                op = OP_WR;
            end
            // Mostly leave tiles switched on
            if (op == OP_CFG_WR) begin
                data = {31'b0, ($urandom_range(3) != 0)};
            end
            send_req(op, tile, addr, data);
        end
        drain_and_check(200);
    endtask

    initial begin
        void'($urandom(1190));
        clk         = 1'b0;
        reset       = 1'b1;
        req_in      = '0;
        rsp_credit  = 1'b0;
        grant_next  = 1'b0;
        errors      = 0;
        rsp_seen    = 0;
        req_credits = RSP_FIFO_DEPTH;
        rsp_granted = 0;
        host_limit  = RSP_FIFO_DEPTH;
        for (int t = 0; t < NUM_TILES; t++) begin
            ref_on[t]    = 1'b1;
            ref_count[t] = '0;
            for (int a = 0; a < BANK_WORDS; a++) begin
                ref_bank[t][a]    = '0;
                ref_written[t][a] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_idle();
        write_then_read();
        bank_independence();
        config_access();
        backpressure_fill_drain();
        random_traffic(60);
        $display("Run finished with %0d errors, %0d responses checked", errors, rsp_seen);
        if (errors == 0) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/glb_top.sv
// Global buffer top: NUM_TILES tiles chained west to east plus egress
// Host keeps RSP_FIFO_DEPTH request credits after reset, one back per req_credit
// Request to FIFO latency is NUM_TILES+1 cycles, chain never stalls
`timescale 1ns/1ps
`default_nettype none

module glb_top (
    input  logic                   clk,
    input  logic                   reset,
    input  glb_pkt_pkg::req_pkt_t  req_in,
    output logic                   req_credit,
    input  logic                   rsp_credit,
    output glb_pkt_pkg::rsp_pkt_t  rsp_out
);
    import glb_param_pkg::*;
    import glb_pkt_pkg::*;

    // chain[k] feeds tile k, chain[NUM_TILES] feeds egress
    chain_slot_t chain [NUM_TILES+1];

    // Host request enters as a request slot
    assign chain[0] = '{is_rsp: 1'b0, req: req_in, rsp: '0};

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
        glb_tile #(
            .TILE_ID (k)
        ) i_tile (
            .clk       (clk),
            .reset     (reset),
            .chain_in  (chain[k]),
            .chain_out (chain[k+1])
        );
    end

    // rsp.valid is only set in response slots
    glb_rsp_egress i_rsp_egress (
        .clk        (clk),
        .reset      (reset),
        .rsp_in     (chain[NUM_TILES].rsp),
        .rsp_credit (rsp_credit),
        .rsp_out    (rsp_out),
        .req_credit (req_credit)
    );

endmodule

`default_nettype wire

//--- source/glb_rsp_egress.sv
// Response FIFO at the east end of the chain with credit-based output
// rsp_out is registered, valid for one cycle per response sent
// Each response sent uses one rsp_credit and returns one req_credit
// Depth must be a power of two, pointers wrap naturally
`timescale 1ns/1ps
`default_nettype none

module glb_rsp_egress (
    input  logic                   clk,
    input  logic                   reset,
    input  glb_pkt_pkg::rsp_pkt_t  rsp_in,
    input  logic                   rsp_credit,
    output glb_pkt_pkg::rsp_pkt_t  rsp_out,
    output logic                   req_credit
);
    import glb_param_pkg::*;
    import glb_pkt_pkg::*;

    rsp_pkt_t                            mem [RSP_FIFO_DEPTH];
    logic [$clog2(RSP_FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(RSP_FIFO_DEPTH)-1:0]   rd_ptr;
    logic [CREDIT_WIDTH-1:0]             fill;
    logic [CREDIT_WIDTH-1:0]             credits;
    logic                                push;
    logic                                pop;

    assign push = rsp_in.valid;
    // Send only with data and a host credit
    assign pop  = (fill != '0) && (credits != '0);

    // FIFO storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rsp_in;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
        end
    end

    // Host response credits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= '0;
        end
        else begin
            case ({rsp_credit, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: ;
            endcase
        end
    end

    // Output register, req_credit rides with rsp_out valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_out    <= '0;
            req_credit <= 1'b0;
        end
        else begin
            rsp_out    <= pop ? mem[rd_ptr] : '0;
            req_credit <= pop;
        end
    end

    // Host obeying req_credit can never fill past depth
    a_no_write_full: assert property (
        @(posedge clk) disable iff (reset)
        push |-> (fill != CREDIT_WIDTH'(RSP_FIFO_DEPTH))
    ) else $error("response FIFO written while full");

    a_no_credit_ovf: assert property (
        @(posedge clk) disable iff (reset)
        (rsp_credit && !pop) |-> (credits != '1)
    ) else $error("response credit counter overflow");

endmodule

`default_nettype wire

//--- source/glb_tile.sv
// One global buffer tile in the east-west chain
// Every slot is registered once here, slot in at t is out at t+1
// Only a request whose tile_id equals TILE_ID is serviced, rest passes through
// Bank ops on a disabled tile return RSP_OFF with zero data
`timescale 1ns/1ps
`default_nettype none

module glb_tile #(
    parameter int TILE_ID = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  glb_pkt_pkg::chain_slot_t  chain_in,
    output glb_pkt_pkg::chain_slot_t  chain_out
);
    import glb_param_pkg::*;
    import glb_pkt_pkg::*;

    glb_cfg_t              cfg;
    logic [DATA_WIDTH-1:0] bank_rdata;
    logic                  hit;
    logic                  bank_op;
    logic                  access_hit;
    logic                  wr_en;
    logic                  cfg_wr;
    rsp_pkt_t              rsp_next;
    chain_slot_t           slot_next;
    chain_slot_t           slot_q;

    // Request addressed to this tile
    assign hit = !chain_in.is_rsp && chain_in.req.valid &&
                 (chain_in.req.tile_id == TILE_ID_WIDTH'(TILE_ID));

    // Opcode decode
    assign bank_op    = (chain_in.req.op == OP_WR) || (chain_in.req.op == OP_RD);
    assign access_hit = hit && bank_op && cfg.tile_on;
    assign wr_en      = access_hit && (chain_in.req.op == OP_WR);
    assign cfg_wr     = hit && (chain_in.req.op == OP_CFG_WR);

    glb_tile_cfg i_tile_cfg (
        .clk        (clk),
        .reset      (reset),
        .cfg_wr     (cfg_wr),
        .cfg_wdata  (chain_in.req.data),
        .access_hit (access_hit),
        .cfg        (cfg)
    );

    glb_tile_core i_tile_core (
        .clk   (clk),
        .reset (reset),
        .wr_en (wr_en),
        .addr  (chain_in.req.word_addr),
        .wdata (chain_in.req.data),
        .rdata (bank_rdata)
    );

    // Response built from the request, header echoed
    always_comb begin
        rsp_next           = '0;
        rsp_next.valid     = 1'b1;
        rsp_next.op        = chain_in.req.op;
        rsp_next.status    = RSP_OK;
        rsp_next.tile_id   = chain_in.req.tile_id;
        rsp_next.word_addr = chain_in.req.word_addr;
        case (chain_in.req.op)
            OP_WR, OP_RD: begin
                if (!cfg.tile_on) begin
                    rsp_next.status = RSP_OFF;
                end
                else if (chain_in.req.op == OP_RD) begin
                    rsp_next.data = bank_rdata;
                end
                else begin
                    // Write ack echoes the stored word
                    rsp_next.data = chain_in.req.data;
                end
            end
            OP_CFG_WR: rsp_next.data = chain_in.req.data;
            OP_CFG_RD: begin
                rsp_next.data[0]                 = cfg.tile_on;
                rsp_next.data[DATA_WIDTH-1 -: 16] = cfg.access_count;
            end
            default: ;
        endcase
    end

    // Serviced slot becomes a response, req half cleared
    always_comb begin
        slot_next = chain_in;
        if (hit) begin
            slot_next.is_rsp = 1'b1;
            slot_next.req    = '0;
            slot_next.rsp    = rsp_next;
        end
    end

    // Pipeline slot
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot_q <= '0;
        end
        else begin
            slot_q <= slot_next;
        end
    end

    assign chain_out = slot_q;

    // Upstream tiles only ever answer for lower ids
    a_rsp_from_west: assert property (
        @(posedge clk) disable iff (reset)
        (chain_in.is_rsp && chain_in.rsp.valid) |->
            (int'(chain_in.rsp.tile_id) < TILE_ID)
    ) else $error("response from west with tile_id %0d at tile %0d",
                  chain_in.rsp.tile_id, TILE_ID);

endmodule

`default_nettype wire

//--- source/glb_tile_core.sv
// Tile SRAM bank, one write or read port shared on addr
// Write is synchronous, read is asynchronous (same-cycle data)
// Reset does not clear the array, contents are undefined until written
// Writes are ignored while reset is high
`timescale 1ns/1ps
`default_nettype none

module glb_tile_core (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       wr_en,
    input  logic [glb_param_pkg::WORD_ADDR_WIDTH-1:0]  addr,
    input  logic [glb_param_pkg::DATA_WIDTH-1:0]       wdata,
    output logic [glb_param_pkg::DATA_WIDTH-1:0]       rdata
);
    import glb_param_pkg::*;

    // Bank storage
    logic [DATA_WIDTH-1:0] mem [BANK_WORDS];

    // Qualified write strobe
    logic                  write_ok;

    // No stray writes from a slot that is being flushed
    assign write_ok = wr_en && !reset;

    // Write port
    always_ff @(posedge clk) begin
        if (write_ok) begin
            mem[addr] <= wdata;
        end
    end

    // Read port
    // tile turns this into a response in the same cycle
    assign rdata = mem[addr];

endmodule

`default_nettype wire

//--- source/glb_tile_cfg.sv
// Per-tile configuration register
// tile_on comes out of reset set, access_count saturates at all ones
// Only bit 0 of cfg_wdata is stored
`timescale 1ns/1ps
`default_nettype none

module glb_tile_cfg (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  cfg_wr,
    input  logic [glb_param_pkg::DATA_WIDTH-1:0]  cfg_wdata,
    input  logic                                  access_hit,
    output glb_pkt_pkg::glb_cfg_t                 cfg
);

    // Enable bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg.tile_on <= 1'b1;
        end
        else if (cfg_wr) begin
            cfg.tile_on <= cfg_wdata[0];
        end
    end

    // Serviced bank accesses
    // holds at max instead of wrapping
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg.access_count <= '0;
        end
        else if (access_hit) begin
            if (cfg.access_count != '1) begin
                cfg.access_count <= cfg.access_count + 16'd1;
            end
        end
    end

    // Both strobes come from one opcode in the tile decode
    a_cfg_wr_excl_hit: assert property (
        @(posedge clk) disable iff (reset)
        !(cfg_wr && access_hit)
    ) else $error("cfg_wr and access_hit high in the same cycle");

endmodule

`default_nettype wire

//--- source/glb_pkt_pkg.sv
// Packet formats for the processor path through the tile chain
// A response slot always carries rsp.valid low in its req half and vice versa
// OP_CFG_RD data layout: bit 0 tile_on, bits 31:16 access_count
`default_nettype none

package glb_pkt_pkg;
    import glb_param_pkg::*;

    typedef enum logic [2:0] {
        OP_NONE   = 3'd0,
        OP_WR     = 3'd1,
        OP_RD     = 3'd2,
        OP_CFG_WR = 3'd3,
        OP_CFG_RD = 3'd4
    } glb_op_e;

    // RSP_OFF when the tile bank is switched off
    typedef enum logic {
        RSP_OK  = 1'b0,
        RSP_OFF = 1'b1
    } glb_status_e;

    typedef struct packed {
        logic                       valid;
        glb_op_e                    op;
        logic [TILE_ID_WIDTH-1:0]   tile_id;
        logic [WORD_ADDR_WIDTH-1:0] word_addr;
        logic [DATA_WIDTH-1:0]      data;
    } req_pkt_t;

    typedef struct packed {
        logic                       valid;
        glb_op_e                    op;
        glb_status_e                status;
        logic [TILE_ID_WIDTH-1:0]   tile_id;
        logic [WORD_ADDR_WIDTH-1:0] word_addr;
        logic [DATA_WIDTH-1:0]      data;
    } rsp_pkt_t;

    // One chain slot, is_rsp picks the live half
    typedef struct packed {
        logic     is_rsp;
        req_pkt_t req;
        rsp_pkt_t rsp;
    } chain_slot_t;

    typedef struct packed {
        logic        tile_on;
        logic [15:0] access_count;
    } glb_cfg_t;

endpackage

`default_nettype wire

//--- source/glb_param_pkg.sv
// Sizing constants for the global buffer chain
// TILE_ID_WIDTH must cover NUM_TILES, WORD_ADDR_WIDTH must cover BANK_WORDS
// RSP_FIFO_DEPTH must be a power of two and fit in CREDIT_WIDTH bits
`default_nettype none

package glb_param_pkg;

    // Chain length and tile select
    localparam int NUM_TILES       = 4;
    localparam int TILE_ID_WIDTH   = 2;

    // Per-tile bank geometry
    localparam int BANK_WORDS      = 64;
    localparam int WORD_ADDR_WIDTH = 6;
    localparam int DATA_WIDTH      = 32;

    // Egress FIFO, also the host's starting request credits
    localparam int RSP_FIFO_DEPTH  = 4;
    localparam int CREDIT_WIDTH    = 3;

endpackage

`default_nettype wire
